// File: common/div_macros.svh
// Widths, step counts and exponent biases for the radix-16 divider.
// Included by the core package and by every module that sizes a field
// or counts steps.

`ifndef DIV_MACROS_SVH
`define DIV_MACROS_SVH

// IEEE exponent biases
`define FP_DBL_BIAS 1023
`define FP_SNGL_BIAS 127

// mantissa incl. hidden bit, singles sit at the top
`define DIV_MANT_W 53
// remainder keeps one guard bit below the mantissa
`define DIV_REM_W 54
`define DIV_RADIX_BITS 4
`define DIV_LANES 15

// one hex digit per step
`define DIV_STEPS_DBL 14
`define DIV_STEPS_SNGL 7
`define DIV_QUOT_W 56

// biased exponent difference, with room for sign and overflow
`define DIV_EXP_W 13

`endif

// File: common/fp_fmt_pkg.sv
// Operand and result word formats for the divider.
// A 64-bit word is read either as one double or as one single in the
// low half. Format select and rounding mode travel with each operation.

package fp_fmt_pkg;

  typedef enum logic {
    FMT_DBL  = 1'b0,
    FMT_SNGL = 1'b1
  } fmt_e;

  typedef enum logic {
    RM_TRUNC = 1'b0,
    RM_EVEN  = 1'b1
  } rmode_e;

  typedef struct packed {
    logic        sign;
    logic [10:0] exp;
    logic [51:0] frac;
  } fp_dbl_s;

  // upper half is unused for a single
  typedef struct packed {
    logic [31:0] unused;
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] frac;
  } fp_sngl_s;

  typedef union packed {
    fp_dbl_s  dbl;
    fp_sngl_s sngl;
  } fp_word_u;

endpackage

// File: common/div_core_pkg.sv
// Datapath types for the digit-recurrence core.
// The remainder is held with one guard bit, so it and every divisor
// multiple are in units of half an LSB of the mantissa.

`include "div_macros.svh"

package div_core_pkg;

  typedef logic [`DIV_MANT_W-1:0] mant_t;

  // partial remainder, always below twice the divisor
  typedef logic [`DIV_REM_W-1:0] rem_t;

  // remainder times 16, a divisor multiple or a trial difference
  typedef logic [`DIV_REM_W+`DIV_RADIX_BITS-1:0] wide_t;

  typedef logic [`DIV_RADIX_BITS-1:0] digit_t;

  typedef logic [`DIV_QUOT_W-1:0] quot_t;

endpackage

// File: hw/div_core/div_lane.sv
// One trial subtraction of the radix-16 step.
// Subtracts a divisor multiple from the remainder times 16 and flags a
// non-negative difference. Fifteen of these run side by side.

`timescale 1ns/1ps

module div_lane
  import div_core_pkg::*;
(
  input  wide_t rem16,
  input  wide_t multiple,
  output wide_t diff,
  output logic  ge
);

  logic borrow;

  // one extra bit catches the borrow out of the top
  assign {borrow, diff} = {1'b0, rem16} - {1'b0, multiple};
  assign ge = ~borrow;

endmodule

// File: hw/div_core/div_multiples.sv
// Divisor multiple table for the radix-16 lanes.
// Loads 1x to 15x of the divisor at load, in guard-bit units, and holds
// them for the whole operation.

`timescale 1ns/1ps
`include "div_macros.svh"

module div_multiples
  import div_core_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  load,
  input  mant_t mant_b,
  output wide_t multiple [1:`DIV_LANES]
);

  wide_t b1;
  wide_t b3;
  wide_t b5;
  wide_t b7;
  wide_t b9;
  wide_t b11;
  wide_t b13;
  wide_t b15;

  // odd terms from shifted sums, even ones are shifts of these
  always_comb begin
    b1  = wide_t'({mant_b, 1'b0});
    b3  = b1 + (b1 << 1);
    b5  = b1 + (b1 << 2);
    b7  = (b1 << 3) - b1;
    b9  = b1 + (b1 << 3);
    b11 = (b1 << 3) + b3;
    b13 = (b1 << 3) + b5;
    b15 = (b1 << 4) - b1;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 1; k <= `DIV_LANES; k++)
        multiple[k] <= '0;
    end else if (load) begin
      multiple[1]  <= b1;
      multiple[2]  <= b1 << 1;
      multiple[3]  <= b3;
      multiple[4]  <= b1 << 2;
      multiple[5]  <= b5;
      multiple[6]  <= b3 << 1;
      multiple[7]  <= b7;
      multiple[8]  <= b1 << 3;
      multiple[9]  <= b9;
      multiple[10] <= b5 << 1;
      multiple[11] <= b11;
      multiple[12] <= b3 << 2;
      multiple[13] <= b13;
      multiple[14] <= b7 << 1;
      multiple[15] <= b15;
    end
  end

  a_divisor_normal: assert property (
    @(posedge clk) disable iff (rst) load |-> mant_b[`DIV_MANT_W-1]
  );

endmodule

// File: hw/div_core/digit_select.sv
// Remainder register and quotient digit selection.
// Each step takes the highest lane whose trial difference is not
// negative, keeps that difference as the next remainder and shifts the
// digit into the quotient register.

`timescale 1ns/1ps
`include "div_macros.svh"

module digit_select
  import div_core_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                load,
  input  logic                step,
  input  mant_t               mant_a,
  input  logic [`DIV_LANES:1] ge,
  input  wide_t               diff [1:`DIV_LANES],
  output wide_t               rem16,
  output quot_t               quot,
  output logic                sticky
);

  rem_t   rem;
  rem_t   rem_next;
  digit_t digit;

  assign rem16 = {rem, {`DIV_RADIX_BITS{1'b0}}};

  // digit 0 leaves the shifted remainder as is
  always_comb begin
    digit    = '0;
    rem_next = rem16[`DIV_REM_W-1:0];
    for (int k = 1; k <= `DIV_LANES; k++) begin
      if (ge[k]) begin
        digit    = digit_t'(k);
        rem_next = diff[k][`DIV_REM_W-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rem  <= '0;
      quot <= '0;
    end else if (load) begin
      // a/2 with the guard bit, stays below 2b so digits stay below 16
      rem  <= {1'b0, mant_a};
      quot <= '0;
    end else if (step) begin
      rem  <= rem_next;
      quot <= {quot[`DIV_QUOT_W-`DIV_RADIX_BITS-1:0], digit};
    end
  end

  assign sticky = |rem;

  a_ge_thermometer: assert property (
    @(posedge clk) disable iff (rst) step |-> ((ge & (ge + 1'b1)) == '0)
  );

endmodule

// File: hw/div_ctrl.sv
// Operand decode and step sequencer for the divider.
// Accepts an operation on start while rdy is high, pulses load, runs
// 14 or 7 step cycles, pulses fin and then raises out_en until the
// result is taken with out_can.

`timescale 1ns/1ps
`include "div_macros.svh"

module div_ctrl
  import fp_fmt_pkg::*, div_core_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  fmt_e                  fmt,
  input  rmode_e                rmode,
  input  fp_word_u              opa,
  input  fp_word_u              opb,
  input  logic                  out_can,
  output logic                  rdy,
  output logic                  out_en,
  output logic                  load,
  output logic                  step,
  output logic                  fin,
  output mant_t                 mant_a,
  output mant_t                 mant_b,
  output fmt_e                  fmt_q,
  output rmode_e                rmode_q,
  output logic                  sign_q,
  output logic [`DIV_EXP_W-1:0] exp_base
);

  logic [`DIV_EXP_W-1:0] exp_a;
  logic [`DIV_EXP_W-1:0] exp_b;
  logic [`DIV_EXP_W-1:0] exp_d;
  logic                  sign_d;
  logic [3:0]            cnt;

  assign load = rdy & start;

  // field decode through the view that fmt selects
  always_comb begin
    if (fmt == FMT_DBL) begin
      mant_a = {1'b1, opa.dbl.frac};
      mant_b = {1'b1, opb.dbl.frac};
      exp_a  = `DIV_EXP_W'(opa.dbl.exp);
      exp_b  = `DIV_EXP_W'(opb.dbl.exp);
      sign_d = opa.dbl.sign ^ opb.dbl.sign;
      exp_d  = exp_a - exp_b + `DIV_EXP_W'(`FP_DBL_BIAS);
    end else begin
      mant_a = {1'b1, opa.sngl.frac, {(`DIV_MANT_W - 24){1'b0}}};
      mant_b = {1'b1, opb.sngl.frac, {(`DIV_MANT_W - 24){1'b0}}};
      exp_a  = `DIV_EXP_W'(opa.sngl.exp);
      exp_b  = `DIV_EXP_W'(opb.sngl.exp);
      sign_d = opa.sngl.sign ^ opb.sngl.sign;
      exp_d  = exp_a - exp_b + `DIV_EXP_W'(`FP_SNGL_BIAS);
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      fmt_q    <= fmt;
      rmode_q  <= rmode;
      sign_q   <= sign_d;
      exp_base <= exp_d;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rdy    <= 1'b1;
      step   <= 1'b0;
      fin    <= 1'b0;
      out_en <= 1'b0;
      cnt    <= '0;
    end else begin
      fin <= step && (cnt == 4'd0);
      if (load) begin
        rdy  <= 1'b0;
        step <= 1'b1;
        cnt  <= (fmt == FMT_DBL) ? 4'(`DIV_STEPS_DBL - 1) : 4'(`DIV_STEPS_SNGL - 1);
      end else if (step) begin
        cnt <= cnt - 4'd1;
        if (cnt == 4'd0)
          step <= 1'b0;
      end
      // result handoff, rdy comes back on the consuming edge
      if (fin) begin
        out_en <= 1'b1;
      end else if (out_en && out_can) begin
        out_en <= 1'b0;
        rdy    <= 1'b1;
      end
    end
  end

  a_no_step_while_out: assert property (
    @(posedge clk) disable iff (rst) !(step && out_en)
  );

endmodule

// File: hw/div_round_pack.sv
// Normalize, round and pack stage of the divider.
// Picks the leading quotient bit, rounds under truncate or nearest even
// and writes the result word through the double or single view. The
// result is registered on fin and held until the next operation.

`timescale 1ns/1ps
`include "div_macros.svh"

module div_round_pack
  import fp_fmt_pkg::*, div_core_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  fin,
  input  quot_t                 quot,
  input  logic                  sticky,
  input  fmt_e                  fmt_q,
  input  rmode_e                rmode_q,
  input  logic                  sign_q,
  input  logic [`DIV_EXP_W-1:0] exp_base,
  output fp_word_u              result
);

  localparam int DT = `DIV_QUOT_W - 1;
  localparam int ST = `DIV_STEPS_SNGL * `DIV_RADIX_BITS - 1;

  logic                  lead;
  logic                  rbit;
  logic                  tail;
  logic                  last;
  logic                  inc;
  logic                  carry;
  mant_t                 kept_d;
  logic [23:0]           kept_s;
  logic [53:0]           sum_d;
  logic [24:0]           sum_s;
  logic [`DIV_EXP_W-1:0] exp_r;
  fp_word_u              res_d;

  // leading bit sits at the top digit position or one below
  always_comb begin
    kept_d = '0;
    kept_s = '0;
    if (fmt_q == FMT_DBL) begin
      lead   = quot[DT];
      kept_d = lead ? quot[DT -: 53] : quot[DT-1 -: 53];
      rbit   = lead ? quot[2] : quot[1];
      tail   = lead ? |quot[1:0] : quot[0];
      last   = kept_d[0];
    end else begin
      lead   = quot[ST];
      kept_s = lead ? quot[ST -: 24] : quot[ST-1 -: 24];
      rbit   = lead ? quot[3] : quot[2];
      tail   = lead ? |quot[2:0] : |quot[1:0];
      last   = kept_s[0];
    end
    inc   = (rmode_q == RM_EVEN) && rbit && (tail || sticky || last);
    sum_d = {1'b0, kept_d} + 54'(inc);
    sum_s = {1'b0, kept_s} + 25'(inc);
    // carry out leaves a zero fraction, only the exponent moves
    carry = (fmt_q == FMT_DBL) ? sum_d[53] : sum_s[24];
    exp_r = exp_base - `DIV_EXP_W'(!lead) + `DIV_EXP_W'(carry);
  end

  always_comb begin
    res_d = '0;
    if (fmt_q == FMT_DBL) begin
      res_d.dbl.sign = sign_q;
      res_d.dbl.exp  = exp_r[10:0];
      res_d.dbl.frac = sum_d[51:0];
    end else begin
      res_d.sngl.sign = sign_q;
      res_d.sngl.exp  = exp_r[7:0];
      res_d.sngl.frac = sum_s[22:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst)
      result <= '0;
    else if (fin)
      result <= res_d;
  end

endmodule

// File: hw/fp_div_top.sv
// Radix-16 floating-point divider, double or single, truncate or
// round to nearest even. Operands are accepted on start while rdy is
// high; the result is offered with out_en and held until out_can.
// One operation is in flight at a time.

`timescale 1ns/1ps
`include "div_macros.svh"

module fp_div_top
  import fp_fmt_pkg::*, div_core_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     start,
  input  fmt_e     fmt,
  input  rmode_e   rmode,
  input  fp_word_u opa,
  input  fp_word_u opb,
  output logic     rdy,
  output fp_word_u result,
  output logic     out_en,
  input  logic     out_can
);

  logic                  load;
  logic                  step;
  logic                  fin;
  mant_t                 mant_a;
  mant_t                 mant_b;
  fmt_e                  fmt_q;
  rmode_e                rmode_q;
  logic                  sign_q;
  logic [`DIV_EXP_W-1:0] exp_base;
  wide_t                 multiple [1:`DIV_LANES];
  wide_t                 diff [1:`DIV_LANES];
  logic [`DIV_LANES:1]   ge;
  wide_t                 rem16;
  quot_t                 quot;
  logic                  sticky;

  div_ctrl u_ctrl (
    .clk(clk), .rst(rst), .start(start), .fmt(fmt), .rmode(rmode),
    .opa(opa), .opb(opb), .out_can(out_can),
    .rdy(rdy), .out_en(out_en), .load(load), .step(step), .fin(fin),
    .mant_a(mant_a), .mant_b(mant_b), .fmt_q(fmt_q), .rmode_q(rmode_q),
    .sign_q(sign_q), .exp_base(exp_base)
  );

  div_multiples u_mult (
    .clk(clk), .rst(rst), .load(load), .mant_b(mant_b), .multiple(multiple)
  );

  for (genvar k = 1; k <= `DIV_LANES; k++) begin : g_lane
    div_lane u_lane (
      .rem16(rem16), .multiple(multiple[k]), .diff(diff[k]), .ge(ge[k])
    );
  end

  digit_select u_sel (
    .clk(clk), .rst(rst), .load(load), .step(step), .mant_a(mant_a),
    .ge(ge), .diff(diff), .rem16(rem16), .quot(quot), .sticky(sticky)
  );

  div_round_pack u_pack (
    .clk(clk), .rst(rst), .fin(fin), .quot(quot), .sticky(sticky),
    .fmt_q(fmt_q), .rmode_q(rmode_q), .sign_q(sign_q), .exp_base(exp_base),
    .result(result)
  );

endmodule

// File: verif/fp_div_model.svh
// Reference model and random source for the divider testbench.
// Included inside the testbench module. The model divides the two
// mantissas as wide integers and rounds the quotient to the format.

`ifndef FP_DIV_MODEL_SVH
`define FP_DIV_MODEL_SVH

`include "div_macros.svh"

// 16-bit Galois LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

// quotient of two normal operands, f=1 for single, rm=1 for nearest even
function automatic logic [63:0] fp_div_model(input logic f, input logic rm,
                                             input logic [63:0] a, input logic [63:0] b);
  int           p;
  int           e;
  logic         sign;
  logic         up;
  logic [127:0] ma;
  logic [127:0] mb;
  logic [127:0] num;
  logic [127:0] q;
  logic [127:0] r;
  logic [127:0] kept;
  if (f == 1'b0) begin
    p    = 53;
    sign = a[63] ^ b[63];
    e    = int'(a[62:52]) - int'(b[62:52]) + `FP_DBL_BIAS;
    ma   = {1'b1, a[51:0]};
    mb   = {1'b1, b[51:0]};
  end else begin
    p    = 24;
    sign = a[31] ^ b[31];
    e    = int'(a[30:23]) - int'(b[30:23]) + `FP_SNGL_BIAS;
    ma   = {1'b1, a[22:0]};
    mb   = {1'b1, b[22:0]};
  end
  // p kept bits plus one round bit, quotient normalized to [1,2)
  if (ma < mb) begin
    e   = e - 1;
    num = ma << (p + 1);
  end else begin
    num = ma << p;
  end
  q    = num / mb;
  r    = num % mb;
  kept = q >> 1;
  up   = rm && q[0] && ((r != 0) || kept[0]);
  kept = kept + up;
  if ((kept >> p) != 0) begin
    kept = kept >> 1;
    e    = e + 1;
  end
  if (f == 1'b0)
    return {sign, 11'(e), kept[51:0]};
  return {32'h0, sign, 8'(e), kept[22:0]};
endfunction

`endif

// File: verif/fp_div_tb.sv
// Testbench for the radix-16 floating-point divider.
// Runs a directed table, LFSR-driven random operands checked against
// the reference model, and a back-pressure sequence. Inputs change on
// the falling edge and outputs are sampled there too.

`timescale 1ns/1ps
`include "div_macros.svh"

module fp_div_tb
  import fp_fmt_pkg::*;
();

  localparam int TIMEOUT  = 100;
  localparam int N_RANDOM = 200;

  logic        clk;
  logic        rst;
  logic        start;
  fmt_e        fmt;
  rmode_e      rmode;
  fp_word_u    opa;
  fp_word_u    opb;
  logic        rdy;
  fp_word_u    result;
  logic        out_en;
  logic        out_can;

  int          errors;
  int          tests;
  int          failed;
  logic [15:0] lfsr_state;

  // directed table
  string       t_name [$];
  logic        t_fmt [$];
  logic        t_rm [$];
  logic [63:0] t_a [$];
  logic [63:0] t_b [$];
  logic [63:0] t_exp [$];

  `include "fp_div_model.svh"

  fp_div_top dut0 (
    .clk(clk), .rst(rst), .start(start), .fmt(fmt), .rmode(rmode),
    .opa(opa), .opb(opb), .rdy(rdy), .result(result), .out_en(out_en),
    .out_can(out_can)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    assert (got === exp)
    else begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int err0);
    tests++;
    if (errors == err0) begin
      $display("test %s: ok", name);
    end else begin
      failed++;
      $display("test %s: failed", name);
    end
  endtask

  task automatic add_vec(input string name, input logic f, input logic rm,
                         input logic [63:0] a, input logic [63:0] b, input logic [63:0] e);
    t_name.push_back(name);
    t_fmt.push_back(f);
    t_rm.push_back(rm);
    t_a.push_back(a);
    t_b.push_back(b);
    t_exp.push_back(e);
  endtask

  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i]       = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // called on a falling edge, returns on the one after acceptance
  task automatic issue_op(input logic f, input logic rm, input logic [63:0] a,
                          input logic [63:0] b);
    int n;
    n = 0;
    while (!rdy && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    assert (rdy)
    else begin
      $display("timed out waiting for rdy before start");
      errors++;
    end
    fmt   = fmt_e'(f);
    rmode = rmode_e'(rm);
    opa   = a;
    opb   = b;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic wait_result(output int lat);
    lat = 0;
    while (!out_en && lat < TIMEOUT) begin
      @(negedge clk);
      lat++;
    end
    assert (out_en)
    else begin
      $display("timed out waiting for out_en");
      errors++;
    end
  endtask

  task automatic consume();
    out_can = 1'b1;
    @(negedge clk);
    out_can = 1'b0;
    check_val("out_en", 64'(out_en), 64'd0);
    check_val("rdy", 64'(rdy), 64'd1);
  endtask

  task automatic run_vec(input logic f, input logic rm, input logic [63:0] a,
                         input logic [63:0] b, input logic [63:0] e);
    int lat;
    issue_op(f, rm, a, b);
    wait_result(lat);
    check_val("result", result, e);
    check_val("latency", 64'(lat), f ? 64'd8 : 64'd15);
    consume();
  endtask

  task automatic run_random();
    logic [63:0] f;
    logic [63:0] rm;
    logic [63:0] sa;
    logic [63:0] sb;
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] fa;
    logic [63:0] fb;
    logic [63:0] a;
    logic [63:0] b;
    int          n_upper;
    int          n_lower;
    n_upper = 0;
    n_lower = 0;
    for (int i = 0; i < N_RANDOM; i++) begin
      take_bits(1, f);
      take_bits(1, rm);
      take_bits(1, sa);
      take_bits(1, sb);
      // exponents within 8 of the bias keep the quotient in range
      take_bits(4, ea);
      take_bits(4, eb);
      take_bits(f[0] ? 23 : 52, fa);
      take_bits(f[0] ? 23 : 52, fb);
      if (f[0]) begin
        a = {32'h0, sa[0], 8'(`FP_SNGL_BIAS - 8 + int'(ea)), fa[22:0]};
        b = {32'h0, sb[0], 8'(`FP_SNGL_BIAS - 8 + int'(eb)), fb[22:0]};
      end else begin
        a = {sa[0], 11'(`FP_DBL_BIAS - 8 + int'(ea)), fa[51:0]};
        b = {sb[0], 11'(`FP_DBL_BIAS - 8 + int'(eb)), fb[51:0]};
      end
      if (fa >= fb)
        n_upper++;
      else
        n_lower++;
      run_vec(f[0], rm[0], a, b, fp_div_model(f[0], rm[0], a, b));
    end
    assert (n_upper > 0 && n_lower > 0)
    else begin
      $display("random operands did not reach both leading-bit positions");
      errors++;
    end
  endtask

  task automatic run_backpressure();
    logic [63:0] first;
    int          lat;
    issue_op(1'b0, 1'b1, 64'h3FF0000000000000, 64'h4024000000000000);
    wait_result(lat);
    first = result;
    check_val("result", first, 64'h3FB999999999999A);
    for (int i = 0; i < 30; i++) begin
      // a second operation while the first is held must be ignored
      start = (i == 5);
      if (i == 5) begin
        opa = 64'h4008000000000000;
        opb = 64'h4000000000000000;
      end
      @(negedge clk);
      check_val("out_en", 64'(out_en), 64'd1);
      check_val("result", result, first);
      check_val("rdy", 64'(rdy), 64'd0);
    end
    start = 1'b0;
    consume();
    check_val("result", result, first);
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      check_val("out_en", 64'(out_en), 64'd0);
    end
  endtask

  initial begin
    int err0;
    rst        = 1'b1;
    start      = 1'b0;
    fmt        = FMT_DBL;
    rmode      = RM_EVEN;
    opa        = '0;
    opb        = '0;
    out_can    = 1'b0;
    errors     = 0;
    tests      = 0;
    failed     = 0;
    lfsr_state = 16'd40004;

    add_vec("dbl 3/2 even", 1'b0, 1'b1, 64'h4008000000000000, 64'h4000000000000000,
            64'h3FF8000000000000);
    add_vec("dbl 3/2 trunc", 1'b0, 1'b0, 64'h4008000000000000, 64'h4000000000000000,
            64'h3FF8000000000000);
    add_vec("dbl 1/-4 even", 1'b0, 1'b1, 64'h3FF0000000000000, 64'hC010000000000000,
            64'hBFD0000000000000);
    add_vec("sngl -6/3 even", 1'b1, 1'b1, 64'hC0C00000, 64'h40400000, 64'hC0000000);
    add_vec("sngl 7.5/2.5 trunc", 1'b1, 1'b0, 64'h40F00000, 64'h40200000, 64'h40400000);
    add_vec("dbl 1/10 even", 1'b0, 1'b1, 64'h3FF0000000000000, 64'h4024000000000000,
            64'h3FB999999999999A);
    add_vec("dbl 1/10 trunc", 1'b0, 1'b0, 64'h3FF0000000000000, 64'h4024000000000000,
            64'h3FB9999999999999);
    add_vec("sngl 1/3 even", 1'b1, 1'b1, 64'h3F800000, 64'h40400000, 64'h3EAAAAAB);
    add_vec("sngl 1/3 trunc", 1'b1, 1'b0, 64'h3F800000, 64'h40400000, 64'h3EAAAAAA);

    repeat (5) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    err0 = errors;
    check_val("rdy", 64'(rdy), 64'd1);
    check_val("out_en", 64'(out_en), 64'd0);
    end_test("reset state", err0);

    for (int i = 0; i < t_name.size(); i++) begin
      err0 = errors;
      run_vec(t_fmt[i], t_rm[i], t_a[i], t_b[i], t_exp[i]);
      end_test(t_name[i], err0);
    end

    err0 = errors;
    run_random();
    end_test("random operands", err0);

    err0 = errors;
    run_backpressure();
    end_test("back-pressure", err0);

    $display("tests: %0d run, %0d failed, %0d errors", tests, failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+common
+incdir+verif
common/fp_fmt_pkg.sv
common/div_core_pkg.sv
hw/div_core/div_lane.sv
hw/div_core/div_multiples.sv
hw/div_core/digit_select.sv
hw/div_ctrl.sv
hw/div_round_pack.sv
hw/fp_div_top.sv
verif/fp_div_tb.sv
